//--- Makefile
TOP = tb_axi4_mm
LOG = sim.log

all: run

obj_dir/V$(TOP): axi4_mm.f src/*.sv verification/*.sv
	verilator --binary --timing --assert -f axi4_mm.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f axi4_mm.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

//--- axi4_mm.f
src/axi4_mm_pkg.sv
src/axi4_mm_mem.sv
src/axi4_mm_out_buffer.sv
src/axi4_mm_write_stage.sv
src/axi4_mm_read_stage.sv
src/axi4_mm_v1_0_wrap.sv
verification/tb_axi4_mm.sv

//--- src/axi4_mm_mem.sv
`timescale 1ns/1ps

module axi4_mm_mem import axi4_mm_pkg::*; (
	input logic s00_axi_aclk,
	input logic we,
	input logic [WORD_ADDR_W-1:0] waddr,
	input logic [DATA_W-1:0] wdata,
	input logic [STRB_W-1:0] wstrb,
	input logic re,
	input logic [WORD_ADDR_W-1:0] raddr,
	output logic [DATA_W-1:0] rdata,
	output logic rvalid
);

	logic [DATA_W-1:0] mem [MEM_WORDS] = '{default: '0};

	// byte lanes written independently
	always_ff @(posedge s00_axi_aclk) begin
		if (we) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wstrb[b]) begin
					mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge s00_axi_aclk) begin
		rvalid <= re; // one cycle behind the request
		if (re) begin
			rdata <= mem[raddr];
		end
	end

endmodule

//--- src/axi4_mm_out_buffer.sv
`timescale 1ns/1ps

module axi4_mm_out_buffer #(
	parameter type payload_t = logic
) (
	input logic s00_axi_aclk,
	input logic reset,
	input logic issue,
	output logic slot_free,
	input logic in_valid,
	input payload_t in_payload,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_payload
);

	payload_t slots [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count;
	logic [1:0] pending; // reserved, payload not here yet
	logic pop;

	assign out_valid = (count != 2'd0);
	assign out_payload = slots[rd_ptr];
	assign pop = out_valid && out_ready;

	// the entry leaving this cycle already counts as free
	assign slot_free = ({1'b0, count} + {1'b0, pending} - {2'b00, pop}) < 3'd2;

	always_ff @(posedge s00_axi_aclk) begin
		if (reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
			pending <= 2'd0;
		end else begin
			if (in_valid) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			count <= count + {1'b0, in_valid} - {1'b0, pop};
			pending <= pending + {1'b0, issue} - {1'b0, in_valid};
		end
	end

	always_ff @(posedge s00_axi_aclk) begin
		if (in_valid) begin
			slots[wr_ptr] <= in_payload;
		end
	end

endmodule

//--- src/axi4_mm_pkg.sv
package axi4_mm_pkg;

	localparam int ID_W = 1;
	localparam int DATA_W = 32;
	localparam int ADDR_W = 12; // byte address
	localparam int STRB_W = DATA_W / 8;
	localparam int USER_W = 1;

	localparam int MEM_WORDS = 1024; // 4 KB of 32-bit words
	localparam int WORD_ADDR_W = $clog2(MEM_WORDS);

	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [1:0] BURST_WRAP = 2'b10;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// one beat on the B channel
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [1:0] resp;
	} b_payload_t;

	// one beat on the R channel
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [DATA_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} r_payload_t;

endpackage

//--- src/axi4_mm_read_stage.sv
`timescale 1ns/1ps

module axi4_mm_read_stage import axi4_mm_pkg::*; (
	input logic s00_axi_aclk,
	input logic reset,
	input logic [ID_W-1:0] arid,
	input logic [ADDR_W-1:0] araddr,
	input logic [7:0] arlen,
	input logic [1:0] arburst,
	input logic arvalid,
	output logic arready,
	input logic slot_free,
	output logic mem_re,
	output logic [WORD_ADDR_W-1:0] mem_raddr,
	output logic r_issue,
	output r_payload_t r_tag
);

	typedef enum logic {
		IDLE,
		ISSUE
	} state_t;

	state_t state;
	logic [ID_W-1:0] id_q;
	logic [WORD_ADDR_W-1:0] addr_q;
	logic [7:0] beats_left;
	logic step_q;
	logic err_q;
	logic ar_fire;
	logic last_beat;

	assign arready = (state == IDLE);
	assign ar_fire = arvalid && arready;
	assign last_beat = (beats_left == 8'd0);

	// one read per reserved slot in the R buffer
	assign r_issue = (state == ISSUE) && slot_free;
	assign mem_re = r_issue;
	assign mem_raddr = addr_q;

	assign r_tag.id = id_q;
	assign r_tag.data = '0; // filled in after the memory read
	assign r_tag.resp = err_q ? RESP_SLVERR : RESP_OKAY;
	assign r_tag.last = last_beat;

	always_ff @(posedge s00_axi_aclk) begin
		if (reset) begin
			state <= IDLE;
		end else if (ar_fire) begin
			state <= ISSUE;
		end else if (r_issue && last_beat) begin
			state <= IDLE;
		end
	end

	always_ff @(posedge s00_axi_aclk) begin
		if (ar_fire) begin
			id_q <= arid;
			addr_q <= araddr[ADDR_W-1:2];
			beats_left <= arlen;
			case (arburst)
				BURST_FIXED: begin
					step_q <= 1'b0;
					err_q <= 1'b0;
				end
				BURST_INCR: begin
					step_q <= 1'b1;
					err_q <= 1'b0;
				end
				BURST_WRAP: begin
					step_q <= 1'b0;
					err_q <= 1'b1;
				end
				default: begin
					step_q <= 1'b0;
					err_q <= 1'b1;
				end
			endcase
		end else if (r_issue) begin
			beats_left <= beats_left - 8'd1;
			if (step_q) begin
				addr_q <= addr_q + 1'b1;
			end
		end
	end

endmodule

//--- src/axi4_mm_v1_0_wrap.sv
`timescale 1ns/1ps

module axi4_mm_v1_0_wrap import axi4_mm_pkg::*; (
	input logic s00_axi_aclk,
	input logic reset,
	// size, lock, cache, prot, qos, region and user inputs are not used
	input logic [ID_W-1:0] s00_axi_awid,
	input logic [ADDR_W-1:0] s00_axi_awaddr,
	input logic [7:0] s00_axi_awlen,
	input logic [2:0] s00_axi_awsize,
	input logic [1:0] s00_axi_awburst,
	input logic s00_axi_awlock,
	input logic [3:0] s00_axi_awcache,
	input logic [2:0] s00_axi_awprot,
	input logic [3:0] s00_axi_awqos,
	input logic [3:0] s00_axi_awregion,
	input logic [USER_W-1:0] s00_axi_awuser,
	input logic s00_axi_awvalid,
	output logic s00_axi_awready,
	input logic [DATA_W-1:0] s00_axi_wdata,
	input logic [STRB_W-1:0] s00_axi_wstrb,
	input logic s00_axi_wlast,
	input logic [USER_W-1:0] s00_axi_wuser,
	input logic s00_axi_wvalid,
	output logic s00_axi_wready,
	output logic [ID_W-1:0] s00_axi_bid,
	output logic [1:0] s00_axi_bresp,
	output logic [USER_W-1:0] s00_axi_buser,
	output logic s00_axi_bvalid,
	input logic s00_axi_bready,
	input logic [ID_W-1:0] s00_axi_arid,
	input logic [ADDR_W-1:0] s00_axi_araddr,
	input logic [7:0] s00_axi_arlen,
	input logic [2:0] s00_axi_arsize,
	input logic [1:0] s00_axi_arburst,
	input logic s00_axi_arlock,
	input logic [3:0] s00_axi_arcache,
	input logic [2:0] s00_axi_arprot,
	input logic [3:0] s00_axi_arqos,
	input logic [3:0] s00_axi_arregion,
	input logic [USER_W-1:0] s00_axi_aruser,
	input logic s00_axi_arvalid,
	output logic s00_axi_arready,
	output logic [ID_W-1:0] s00_axi_rid,
	output logic [DATA_W-1:0] s00_axi_rdata,
	output logic [1:0] s00_axi_rresp,
	output logic s00_axi_rlast,
	output logic [USER_W-1:0] s00_axi_ruser,
	output logic s00_axi_rvalid,
	input logic s00_axi_rready
);

	logic mem_we;
	logic [WORD_ADDR_W-1:0] mem_waddr;
	logic [DATA_W-1:0] mem_wdata;
	logic [STRB_W-1:0] mem_wstrb;
	logic b_slot_free;
	logic b_issue;
	logic b_in_valid;
	b_payload_t b_payload;
	b_payload_t b_out;
	logic mem_re;
	logic [WORD_ADDR_W-1:0] mem_raddr;
	logic [DATA_W-1:0] mem_rdata;
	logic mem_rvalid;
	logic r_slot_free;
	logic r_issue;
	r_payload_t r_tag;
	r_payload_t r_tag_q;
	r_payload_t r_in;
	r_payload_t r_out;

	axi4_mm_write_stage u_write (
		.s00_axi_aclk(s00_axi_aclk),
		.reset(reset),
		.awid(s00_axi_awid),
		.awaddr(s00_axi_awaddr),
		.awlen(s00_axi_awlen),
		.awburst(s00_axi_awburst),
		.awvalid(s00_axi_awvalid),
		.awready(s00_axi_awready),
		.wdata(s00_axi_wdata),
		.wstrb(s00_axi_wstrb),
		.wvalid(s00_axi_wvalid),
		.wready(s00_axi_wready),
		.slot_free(b_slot_free),
		.mem_we(mem_we),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.b_issue(b_issue),
		.b_payload(b_payload)
	);

	axi4_mm_read_stage u_read (
		.s00_axi_aclk(s00_axi_aclk),
		.reset(reset),
		.arid(s00_axi_arid),
		.araddr(s00_axi_araddr),
		.arlen(s00_axi_arlen),
		.arburst(s00_axi_arburst),
		.arvalid(s00_axi_arvalid),
		.arready(s00_axi_arready),
		.slot_free(r_slot_free),
		.mem_re(mem_re),
		.mem_raddr(mem_raddr),
		.r_issue(r_issue),
		.r_tag(r_tag)
	);

	axi4_mm_mem u_mem (
		.s00_axi_aclk(s00_axi_aclk),
		.we(mem_we),
		.waddr(mem_waddr),
		.wdata(mem_wdata),
		.wstrb(mem_wstrb),
		.re(mem_re),
		.raddr(mem_raddr),
		.rdata(mem_rdata),
		.rvalid(mem_rvalid)
	);

	// B payload follows its reservation by one cycle
	always_ff @(posedge s00_axi_aclk) begin
		if (reset) begin
			b_in_valid <= 1'b0;
		end else begin
			b_in_valid <= b_issue;
		end
	end

	always_ff @(posedge s00_axi_aclk) begin
		if (mem_re) begin
			r_tag_q <= r_tag; // lines up with mem_rdata
		end
	end

	always_comb begin
		r_in = r_tag_q;
		if (r_tag_q.resp == RESP_OKAY) begin
			r_in.data = mem_rdata; // error beats keep zero data
		end
	end

	axi4_mm_out_buffer #(.payload_t(b_payload_t)) u_b_buf (
		.s00_axi_aclk(s00_axi_aclk),
		.reset(reset),
		.issue(b_issue),
		.slot_free(b_slot_free),
		.in_valid(b_in_valid),
		.in_payload(b_payload),
		.out_valid(s00_axi_bvalid),
		.out_ready(s00_axi_bready),
		.out_payload(b_out)
	);

	axi4_mm_out_buffer #(.payload_t(r_payload_t)) u_r_buf (
		.s00_axi_aclk(s00_axi_aclk),
		.reset(reset),
		.issue(r_issue),
		.slot_free(r_slot_free),
		.in_valid(mem_rvalid),
		.in_payload(r_in),
		.out_valid(s00_axi_rvalid),
		.out_ready(s00_axi_rready),
		.out_payload(r_out)
	);

	assign s00_axi_bid = b_out.id;
	assign s00_axi_bresp = b_out.resp;
	assign s00_axi_buser = '0;

	assign s00_axi_rid = r_out.id;
	assign s00_axi_rdata = r_out.data;
	assign s00_axi_rresp = r_out.resp;
	assign s00_axi_rlast = r_out.last;
	assign s00_axi_ruser = '0;

endmodule

//--- src/axi4_mm_write_stage.sv
`timescale 1ns/1ps

module axi4_mm_write_stage import axi4_mm_pkg::*; (
	input logic s00_axi_aclk,
	input logic reset,
	input logic [ID_W-1:0] awid,
	input logic [ADDR_W-1:0] awaddr,
	input logic [7:0] awlen,
	input logic [1:0] awburst,
	input logic awvalid,
	output logic awready,
	input logic [DATA_W-1:0] wdata,
	input logic [STRB_W-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	input logic slot_free,
	output logic mem_we,
	output logic [WORD_ADDR_W-1:0] mem_waddr,
	output logic [DATA_W-1:0] mem_wdata,
	output logic [STRB_W-1:0] mem_wstrb,
	output logic b_issue,
	output b_payload_t b_payload
);

	typedef enum logic {
		IDLE,
		DATA
	} state_t;

	state_t state;
	logic [ID_W-1:0] id_q;
	logic [WORD_ADDR_W-1:0] addr_q;
	logic [7:0] beats_left;
	logic step_q;
	logic err_q;
	logic aw_fire;
	logic w_fire;
	logic last_beat;

	assign awready = (state == IDLE);
	assign aw_fire = awvalid && awready;
	assign wready = (state == DATA) && slot_free; // B buffer must have room
	assign w_fire = wvalid && wready;
	assign last_beat = (beats_left == 8'd0); // wlast not checked

	assign mem_we = w_fire && !err_q; // wrap bursts leave memory alone
	assign mem_waddr = addr_q;
	assign mem_wdata = wdata;
	assign mem_wstrb = wstrb;

	assign b_issue = w_fire && last_beat;
	assign b_payload.id = id_q;
	assign b_payload.resp = err_q ? RESP_SLVERR : RESP_OKAY;

	always_ff @(posedge s00_axi_aclk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (aw_fire) begin
						state <= DATA;
					end
				end
				DATA: begin
					if (b_issue) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge s00_axi_aclk) begin
		if (aw_fire) begin
			id_q <= awid;
			addr_q <= awaddr[ADDR_W-1:2]; // byte to word index
			beats_left <= awlen;
			case (awburst)
				BURST_FIXED: begin
					step_q <= 1'b0;
					err_q <= 1'b0;
				end
				BURST_INCR: begin
					step_q <= 1'b1;
					err_q <= 1'b0;
				end
				BURST_WRAP: begin
					step_q <= 1'b0;
					err_q <= 1'b1;
				end
				default: begin
					step_q <= 1'b0; // reserved code, answered like wrap
					err_q <= 1'b1;
				end
			endcase
		end else if (w_fire) begin
			beats_left <= beats_left - 8'd1;
			if (step_q) begin
				addr_q <= addr_q + 1'b1;
			end
		end
	end

endmodule

//--- verification/tb_axi4_mm.sv
`timescale 1ns/1ps

module tb_axi4_mm import axi4_mm_pkg::*; ();

	localparam int N_BURSTS = 8;

	logic s00_axi_aclk = 1'b0;
	logic reset;
	logic [ID_W-1:0] s00_axi_awid, s00_axi_bid, s00_axi_arid, s00_axi_rid;
	logic [ADDR_W-1:0] s00_axi_awaddr, s00_axi_araddr;
	logic [7:0] s00_axi_awlen, s00_axi_arlen;
	logic [1:0] s00_axi_awburst, s00_axi_arburst, s00_axi_bresp, s00_axi_rresp;
	logic [2:0] s00_axi_awsize = 3'd2, s00_axi_arsize = 3'd2;
	logic [2:0] s00_axi_awprot = 3'd0, s00_axi_arprot = 3'd0;
	logic s00_axi_awlock = 1'b0, s00_axi_arlock = 1'b0;
	logic [3:0] s00_axi_awcache = 4'd0, s00_axi_arcache = 4'd0;
	logic [3:0] s00_axi_awqos = 4'd0, s00_axi_arqos = 4'd0;
	logic [3:0] s00_axi_awregion = 4'd0, s00_axi_arregion = 4'd0;
	logic [USER_W-1:0] s00_axi_awuser = '0, s00_axi_wuser = '0, s00_axi_aruser = '0;
	logic [USER_W-1:0] s00_axi_buser, s00_axi_ruser;
	logic s00_axi_awvalid, s00_axi_awready, s00_axi_wvalid, s00_axi_wready, s00_axi_wlast;
	logic s00_axi_bvalid, s00_axi_bready, s00_axi_arvalid, s00_axi_arready;
	logic s00_axi_rvalid, s00_axi_rready, s00_axi_rlast;
	logic [DATA_W-1:0] s00_axi_wdata, s00_axi_rdata;
	logic [STRB_W-1:0] s00_axi_wstrb;

	logic [DATA_W-1:0] ref_mem [MEM_WORDS] = '{default: '0}; // reference memory
	b_payload_t exp_b [64];
	r_payload_t exp_r [1024];
	int b_head = 0, b_tail = 0, r_head = 0, r_tail = 0;
	logic [WORD_ADDR_W-1:0] w_word;
	logic [1:0] w_burst;
	logic [ID_W-1:0] exp_bid, exp_rid;
	logic [1:0] exp_bresp, exp_rresp;
	logic [DATA_W-1:0] exp_rdata;
	logic exp_rlast;

	logic [31:0] stim_rng = 32'd68437;
	logic [31:0] ready_rng = 32'd68437;
	int burst_len [N_BURSTS];
	logic [WORD_ADDR_W-1:0] burst_word [N_BURSTS];
	logic [DATA_W-1:0] beat_data [16];
	logic [STRB_W-1:0] beat_strb [16];
	int errors = 0, tests = 0, failed_tests = 0;
	int cycles = 0, cycle_limit = 0;

	axi4_mm_v1_0_wrap uut (.*);

	always #20 s00_axi_aclk = ~s00_axi_aclk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic flag_error(input string what);
		$display("ERROR at %0d ns: %s", $time, what);
		errors++;
	endtask

	task automatic write_burst(input logic [ID_W-1:0] id, input logic [WORD_ADDR_W-1:0] word,
			input int len, input logic [1:0] burst);
		@(posedge s00_axi_aclk);
		s00_axi_awid <= id;
		s00_axi_awaddr <= {word, 2'b00};
		s00_axi_awlen <= 8'(len - 1);
		s00_axi_awburst <= burst;
		s00_axi_awvalid <= 1'b1;
		do @(negedge s00_axi_aclk); while (!s00_axi_awready);
		@(posedge s00_axi_aclk);
		s00_axi_awvalid <= 1'b0;
		for (int i = 0; i < len; i++) begin
			s00_axi_wdata <= beat_data[i];
			s00_axi_wstrb <= beat_strb[i];
			s00_axi_wlast <= (i == len - 1);
			s00_axi_wvalid <= 1'b1;
			do @(negedge s00_axi_aclk); while (!s00_axi_wready); // stalls on full B buffer
			@(posedge s00_axi_aclk);
		end
		s00_axi_wvalid <= 1'b0;
		s00_axi_wlast <= 1'b0;
	endtask

	task automatic read_burst(input logic [ID_W-1:0] id, input logic [WORD_ADDR_W-1:0] word,
			input int len, input logic [1:0] burst);
		@(posedge s00_axi_aclk);
		s00_axi_arid <= id;
		s00_axi_araddr <= {word, 2'b00};
		s00_axi_arlen <= 8'(len - 1);
		s00_axi_arburst <= burst;
		s00_axi_arvalid <= 1'b1;
		do @(negedge s00_axi_aclk); while (!s00_axi_arready);
		@(posedge s00_axi_aclk);
		s00_axi_arvalid <= 1'b0;
	endtask

	// all expected B and R beats consumed
	task automatic wait_quiet();
		do @(negedge s00_axi_aclk); while (b_head != b_tail || r_head != r_tail);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	always @(posedge s00_axi_aclk) begin
		ready_rng = xorshift32(ready_rng);
		s00_axi_bready <= (ready_rng[1:0] != 2'b00); // ready about 3 cycles in 4
		s00_axi_rready <= (ready_rng[3:2] != 2'b00);
	end

	// model follows the transfers seen at the ports
	always @(posedge s00_axi_aclk) begin
		logic [WORD_ADDR_W-1:0] ra;
		logic wrap_r;
		if (!reset) begin
			if (s00_axi_awvalid && s00_axi_awready) begin
				w_word <= s00_axi_awaddr[ADDR_W-1:2];
				w_burst <= s00_axi_awburst;
				exp_b[b_tail] <= '{id: s00_axi_awid,
					resp: (s00_axi_awburst == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY};
				b_tail <= b_tail + 1;
			end
			if (s00_axi_wvalid && s00_axi_wready) begin
				if (w_burst != BURST_WRAP) begin
					for (int k = 0; k < STRB_W; k++) begin
						if (s00_axi_wstrb[k]) begin
							ref_mem[w_word][8*k +: 8] <= s00_axi_wdata[8*k +: 8];
						end
					end
				end
				if (w_burst == BURST_INCR) begin
					w_word <= w_word + 1'b1;
				end
			end
			if (s00_axi_arvalid && s00_axi_arready) begin
				wrap_r = (s00_axi_arburst == BURST_WRAP);
				ra = s00_axi_araddr[ADDR_W-1:2];
				for (int k = 0; k <= int'(s00_axi_arlen); k++) begin
					exp_r[r_tail + k] <= '{id: s00_axi_arid, data: wrap_r ? '0 : ref_mem[ra],
						resp: wrap_r ? RESP_SLVERR : RESP_OKAY,
						last: (k == int'(s00_axi_arlen))};
					if (s00_axi_arburst == BURST_INCR) begin
						ra = ra + 1'b1;
					end
				end
				r_tail <= r_tail + int'(s00_axi_arlen) + 1;
			end
			if (s00_axi_bvalid && s00_axi_bready) begin
				b_head <= b_head + 1;
			end
			if (s00_axi_rvalid && s00_axi_rready) begin
				r_head <= r_head + 1;
			end
		end
	end

	assign exp_bid = exp_b[b_head].id;
	assign exp_bresp = exp_b[b_head].resp;
	assign exp_rid = exp_r[r_head].id;
	assign exp_rdata = exp_r[r_head].data;
	assign exp_rresp = exp_r[r_head].resp;
	assign exp_rlast = exp_r[r_head].last;

	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		s00_axi_bvalid |-> (b_head != b_tail))
		else flag_error("B response with no write outstanding");
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		s00_axi_rvalid |-> (r_head != r_tail))
		else flag_error("R beat with no read outstanding");
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		(s00_axi_bvalid && s00_axi_bready) |-> (s00_axi_bid == exp_bid))
		else mismatch("s00_axi_bid", 32'($sampled(exp_bid)), 32'($sampled(s00_axi_bid)));
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		(s00_axi_bvalid && s00_axi_bready) |-> (s00_axi_bresp == exp_bresp))
		else mismatch("s00_axi_bresp", 32'($sampled(exp_bresp)), 32'($sampled(s00_axi_bresp)));
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		s00_axi_bvalid |-> (s00_axi_buser == '0))
		else mismatch("s00_axi_buser", 32'd0, 32'($sampled(s00_axi_buser)));
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		(s00_axi_rvalid && s00_axi_rready) |-> (s00_axi_rid == exp_rid))
		else mismatch("s00_axi_rid", 32'($sampled(exp_rid)), 32'($sampled(s00_axi_rid)));
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		(s00_axi_rvalid && s00_axi_rready) |-> (s00_axi_rdata == exp_rdata))
		else mismatch("s00_axi_rdata", $sampled(exp_rdata), $sampled(s00_axi_rdata));
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		(s00_axi_rvalid && s00_axi_rready) |-> (s00_axi_rresp == exp_rresp))
		else mismatch("s00_axi_rresp", 32'($sampled(exp_rresp)), 32'($sampled(s00_axi_rresp)));
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		(s00_axi_rvalid && s00_axi_rready) |-> (s00_axi_rlast == exp_rlast))
		else mismatch("s00_axi_rlast", 32'($sampled(exp_rlast)), 32'($sampled(s00_axi_rlast)));
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		s00_axi_rvalid |-> (s00_axi_ruser == '0))
		else mismatch("s00_axi_ruser", 32'd0, 32'($sampled(s00_axi_ruser)));
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		(s00_axi_bvalid && !s00_axi_bready) |=>
		(s00_axi_bvalid && $stable(s00_axi_bid) && $stable(s00_axi_bresp)))
		else flag_error("B response changed or dropped while bready was low");
	assert property (@(posedge s00_axi_aclk) disable iff (reset)
		(s00_axi_rvalid && !s00_axi_rready) |=> (s00_axi_rvalid && $stable(s00_axi_rid)
		&& $stable(s00_axi_rdata) && $stable(s00_axi_rresp) && $stable(s00_axi_rlast)))
		else flag_error("R beat changed or dropped while rready was low");

	always @(posedge s00_axi_aclk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int beats;
		int start;
		reset = 1'b1;
		s00_axi_awvalid = 1'b0;
		s00_axi_wvalid = 1'b0;
		s00_axi_wlast = 1'b0;
		s00_axi_arvalid = 1'b0;
		s00_axi_bready = 1'b0;
		s00_axi_rready = 1'b0;
		s00_axi_awid = '0;
		s00_axi_awaddr = '0;
		s00_axi_awlen = '0;
		s00_axi_awburst = BURST_INCR;
		s00_axi_wdata = '0;
		s00_axi_wstrb = '0;
		s00_axi_arid = '0;
		s00_axi_araddr = '0;
		s00_axi_arlen = '0;
		s00_axi_arburst = BURST_INCR;

		beats = 3 + 8 + 12; // directed, fixed and wrap tests
		for (int b = 0; b < N_BURSTS; b++) begin
			stim_rng = xorshift32(stim_rng);
			burst_len[b] = int'(stim_rng[3:0]) + 1;
			burst_word[b] = stim_rng[13:4] % 10'd1008; // burst stays inside memory
			beats += 2 * burst_len[b];
		end
		cycle_limit = 4 * (beats + 20 * (3 + 2 * N_BURSTS + 2 + 3));

		repeat (4) @(posedge s00_axi_aclk);
		reset <= 1'b0;

		@(negedge s00_axi_aclk);
		start = errors;
		assert (s00_axi_awready && s00_axi_arready && !s00_axi_wready
			&& !s00_axi_bvalid && !s00_axi_rvalid)
			else flag_error("handshake levels wrong after reset");
		finish_test("reset_state", start);

		start = errors;
		beat_data[0] = 32'h12345678;
		beat_strb[0] = 4'b1111;
		write_burst(1'b1, 10'd0, 1, BURST_INCR);
		beat_data[0] = 32'h00000000;
		beat_strb[0] = 4'b1000; // top byte only
		write_burst(1'b0, 10'd0, 1, BURST_INCR);
		read_burst(1'b1, 10'd0, 1, BURST_INCR);
		wait_quiet();
		finish_test("reference_sequence", start);

		start = errors;
		for (int b = 0; b < N_BURSTS; b++) begin
			for (int i = 0; i < burst_len[b]; i++) begin
				stim_rng = xorshift32(stim_rng);
				beat_data[i] = stim_rng;
				beat_strb[i] = stim_rng[7:4];
			end
			write_burst(b[0], burst_word[b], burst_len[b], BURST_INCR);
		end
		wait_quiet();
		for (int b = 0; b < N_BURSTS; b++) begin
			read_burst(~b[0], burst_word[b], burst_len[b], BURST_INCR);
		end
		wait_quiet();
		finish_test("incr_bursts", start);

		start = errors;
		for (int i = 0; i < 4; i++) begin
			stim_rng = xorshift32(stim_rng);
			beat_data[i] = stim_rng;
			beat_strb[i] = stim_rng[11:8];
		end
		write_burst(1'b1, 10'h040, 4, BURST_FIXED);
		read_burst(1'b0, 10'h040, 4, BURST_FIXED);
		wait_quiet();
		finish_test("fixed_bursts", start);

		start = errors;
		for (int i = 0; i < 4; i++) begin
			beat_data[i] = 32'hdead_0000 | 32'(i);
			beat_strb[i] = 4'b1111;
		end
		write_burst(1'b0, 10'h040, 4, BURST_WRAP);
		read_burst(1'b1, 10'h040, 4, BURST_INCR);
		read_burst(1'b0, 10'h040, 4, BURST_WRAP);
		wait_quiet();
		finish_test("wrap_bursts", start);

		$display("tests %0d, tests with errors %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
